//--- common/vector_pkg.sv
package vector_pkg;

	////////////////////////////////////////////////////////////
	// Bus types
	////////////////////////////////////////////////////////////

	typedef logic [15:0] addr_t;    // CPU address
	typedef logic [7:0]  byte_t;    // Data bus byte
	typedef logic [2:0]  page_t;    // Ramdisk page, 0 is main memory
	typedef logic [7:0]  status_t;  // 8080 status word

	////////////////////////////////////////////////////////////
	// 8080 status word bits
	////////////////////////////////////////////////////////////

	localparam int st_interrupt_ack = 0;
	localparam int st_write_n       = 1;  // Low on any write cycle
	localparam int st_stack         = 2;
	localparam int st_io_write      = 4;
	localparam int st_io_read       = 6;
	localparam int st_mem_read      = 7;

	////////////////////////////////////////////////////////////
	// I/O ports
	////////////////////////////////////////////////////////////

	localparam byte_t port_video_mode = 8'h01;  // Border, mode512, palette address
	localparam byte_t port_scroll     = 8'h02;
	localparam byte_t port_palette    = 8'h0C;  // Palette value
	localparam byte_t port_ramdisk    = 8'h10;  // Ramdisk control register

	// Boot ROM occupies the bottom of the address space
	localparam int rom_size = 2048;

	// Ramdisk window in the CPU address space
	localparam addr_t window_lo = 16'hA000;
	localparam addr_t window_hi = 16'hDFFF;

	////////////////////////////////////////////////////////////
	// Video control registers
	////////////////////////////////////////////////////////////

	typedef struct packed {
		byte_t       scroll;        // Vertical scroll line
		logic [3:0]  border_index;  // Palette entry used for the border
		logic        mode512;       // 512 pixel mode
		logic [3:0]  palette_addr;  // Entry written by the next palette write
	} video_ctl_t;

endpackage

//--- hdl/bus_control.sv
`timescale 1ns/1ps

module bus_control (
	input  logic                clk24,
	input  logic                mreset,
	input  logic                cpu_ce,
	input  logic                sync,
	input  logic                wr_n,
	input  vector_pkg::addr_t   addr,
	input  vector_pkg::byte_t   dout,
	output vector_pkg::status_t status,
	output vector_pkg::byte_t   port,
	output logic                ready,
	output logic                wr_ramdisk,
	output logic                wr_video_mode,
	output logic                wr_scroll,
	output logic                wr_palette
);
	import vector_pkg::*;

	logic need_wait;       // Memory or stack cycle being announced
	logic io_write_cycle;  // Data phase of an OUT instruction

	////////////////////////////////////////////////////////////
	// Status word and wait state
	////////////////////////////////////////////////////////////

	// Every cycle that is not an I/O write, or that reads memory, gets one wait
	assign need_wait = dout[st_mem_read] | ~dout[st_io_write];

	always_ff @(posedge clk24) begin
		if (mreset) begin
			status <= '0;
			ready <= 1'b1;
		end else if (cpu_ce) begin
			if (sync) begin
				status <= dout;  // Status is on the data bus during sync
				ready <= ~need_wait;
			end else begin
				ready <= 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Port address
	////////////////////////////////////////////////////////////

	// The 8080 puts the port number on the low address byte
	always_ff @(posedge clk24) begin
		if (cpu_ce) begin
			port <= addr[7:0];
		end
	end

	////////////////////////////////////////////////////////////
	// Port write strobes
	////////////////////////////////////////////////////////////

	assign io_write_cycle = cpu_ce & ~wr_n & status[st_io_write];

	// One clock wide, targets load on the same edge
	assign wr_ramdisk    = io_write_cycle & (port == port_ramdisk);
	assign wr_video_mode = io_write_cycle & (port == port_video_mode);
	assign wr_scroll     = io_write_cycle & (port == port_scroll);
	assign wr_palette    = io_write_cycle & (port == port_palette);

endmodule

//--- kvaz/kvaz.sv
`timescale 1ns/1ps

module kvaz (
	input  logic                clk24,
	input  logic                mreset,
	input  logic                wr_ramdisk,
	input  vector_pkg::byte_t   dout,
	input  vector_pkg::addr_t   addr,
	input  vector_pkg::status_t status,
	output vector_pkg::page_t   ram_page
);
	import vector_pkg::*;

	// Control register layout
	//   bit 5    stack mapping on
	//   bit 4    window mapping on
	//   bits 3:2 stack page
	//   bits 1:0 window page
	byte_t ctl;

	logic stack_cycle;
	logic mem_cycle;
	logic in_window;
	logic stack_map;
	logic window_map;

	always_ff @(posedge clk24) begin
		if (mreset) begin
			ctl <= '0;  // Everything in main memory
		end else if (wr_ramdisk) begin
			ctl <= dout;
		end
	end

	////////////////////////////////////////////////////////////
	// Cycle classification
	////////////////////////////////////////////////////////////

	assign stack_cycle = status[st_stack];
	assign mem_cycle   = status[st_mem_read] | ~status[st_write_n];
	assign in_window   = (addr >= window_lo) && (addr <= window_hi);

	assign stack_map  = ctl[5] & stack_cycle;
	assign window_map = ctl[4] & mem_cycle & in_window;

	////////////////////////////////////////////////////////////
	// Page select
	////////////////////////////////////////////////////////////

	// Stack mapping wins over the window
	always_comb begin
		if (stack_map) begin
			ram_page = {1'b0, ctl[3:2]} + 3'd1;
		end else if (window_map) begin
			ram_page = {1'b0, ctl[1:0]} + 3'd1;
		end else begin
			ram_page = '0;
		end
	end

endmodule

//--- hdl/video_regs.sv
`timescale 1ns/1ps

module video_regs (
	input  logic                   clk24,
	input  logic                   mreset,
	input  logic                   retrace,
	input  logic                   wr_video_mode,
	input  logic                   wr_scroll,
	input  logic                   wr_palette,
	input  vector_pkg::byte_t      dout,
	output vector_pkg::video_ctl_t video_ctl,
	output vector_pkg::byte_t      palette_value,
	output logic                   palette_wren
);
	import vector_pkg::*;

	////////////////////////////////////////////////////////////
	// Scroll and mode
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk24) begin
		if (mreset) begin
			video_ctl <= '0;
		end else begin
			if (wr_scroll) begin
				video_ctl.scroll <= dout;
			end
			if (wr_video_mode) begin
				// Same port means palette address while the beam is off screen
				if (retrace) begin
					video_ctl.palette_addr <= dout[3:0];
				end else begin
					video_ctl.border_index <= dout[3:0];
					video_ctl.mode512 <= dout[4];
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Palette write
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk24) begin
		if (wr_palette) begin
			palette_value <= dout;
		end
	end

	// Palette RAM write enable, follows the port write by one clock
	always_ff @(posedge clk24) begin
		if (mreset) begin
			palette_wren <= 1'b0;
		end else begin
			palette_wren <= wr_palette;
		end
	end

endmodule

//--- hdl/cpu_data_mux.sv
`timescale 1ns/1ps

module cpu_data_mux (
	input  vector_pkg::status_t status,
	input  vector_pkg::addr_t   addr,
	input  logic                rom_disable,
	input  vector_pkg::byte_t   rom_data,
	input  vector_pkg::byte_t   sram_data,
	input  vector_pkg::byte_t   ext_io_data,
	output vector_pkg::byte_t   din
);
	import vector_pkg::*;

	logic int_ack;
	logic io_read;
	logic rom_area;

	assign int_ack = status[st_interrupt_ack];
	assign io_read = status[st_io_read];

	// Boot ROM shadows low memory until the restart key
	assign rom_area = ~rom_disable & (addr < addr_t'(rom_size));

	////////////////////////////////////////////////////////////
	// Read data select
	////////////////////////////////////////////////////////////

	always_comb begin
		if (int_ack) begin
			din = 8'hFF;  // RST 7 on the bus
		end else if (io_read) begin
			din = ext_io_data;
		end else if (rom_area) begin
			din = rom_data;
		end else begin
			din = sram_data;
		end
	end

endmodule

//--- hdl/restart_irq.sv
`timescale 1ns/1ps

module restart_irq (
	input  logic clk24,
	input  logic mreset,
	input  logic cpu_ce,
	input  logic retrace,
	input  logic blksbr,
	output logic int_req,
	output logic rom_disable,
	output logic cpu_reset_n
);
	// Bit 0 is the retrace detector, bit 1 the restart key detector
	logic [1:0] level;
	logic [1:0] level_q;  // Value at the previous CPU cycle
	logic [1:0] pulse;    // One CPU cycle per rising edge

	assign level = {blksbr, retrace};

	////////////////////////////////////////////////////////////
	// Edge detectors on the CPU clock
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk24) begin
		if (mreset) begin
			level_q <= '0;
			pulse <= '0;
		end else if (cpu_ce) begin
			level_q <= level;
			pulse <= level & ~level_q;  // Cleared again on the next cpu_ce
		end
	end

	// Once the key is seen, low memory stays RAM
	always_ff @(posedge clk24) begin
		if (mreset) begin
			rom_disable <= 1'b0;
		end else if (cpu_ce && blksbr) begin
			rom_disable <= 1'b1;
		end
	end

	assign int_req     = pulse[0];
	assign cpu_reset_n = ~pulse[1];

endmodule

//--- hdl/vector_io.sv
`timescale 1ns/1ps

module vector_io (
	input  logic                   clk24,
	input  logic                   mreset,
	input  logic                   cpu_ce,
	input  logic                   sync,
	input  logic                   wr_n,
	input  vector_pkg::addr_t      addr,
	input  vector_pkg::byte_t      dout,
	input  vector_pkg::byte_t      rom_data,
	input  vector_pkg::byte_t      sram_data,
	input  vector_pkg::byte_t      ext_io_data,
	input  logic                   retrace,
	input  logic                   blksbr,
	output vector_pkg::byte_t      din,
	output logic                   ready,
	output logic                   int_req,
	output logic                   cpu_reset_n,
	output logic                   rom_disable,
	output vector_pkg::page_t      ram_page,
	output vector_pkg::video_ctl_t video_ctl,
	output vector_pkg::byte_t      palette_value,
	output logic                   palette_wren
);
	import vector_pkg::*;

	status_t status;
	byte_t   port;
	logic    wr_ramdisk;
	logic    wr_video_mode;
	logic    wr_scroll;
	logic    wr_palette;

	////////////////////////////////////////////////////////////
	// Bus cycle decode
	////////////////////////////////////////////////////////////

	bus_control i_bus_control (
		.clk24         (clk24),
		.mreset        (mreset),
		.cpu_ce        (cpu_ce),
		.sync          (sync),
		.wr_n          (wr_n),
		.addr          (addr),
		.dout          (dout),
		.status        (status),
		.port          (port),
		.ready         (ready),
		.wr_ramdisk    (wr_ramdisk),
		.wr_video_mode (wr_video_mode),
		.wr_scroll     (wr_scroll),
		.wr_palette    (wr_palette)
	);

	////////////////////////////////////////////////////////////
	// Datapath blocks
	////////////////////////////////////////////////////////////

	kvaz i_kvaz (
		.clk24      (clk24),
		.mreset     (mreset),
		.wr_ramdisk (wr_ramdisk),
		.dout       (dout),
		.addr       (addr),
		.status     (status),
		.ram_page   (ram_page)
	);

	video_regs i_video_regs (
		.clk24         (clk24),
		.mreset        (mreset),
		.retrace       (retrace),
		.wr_video_mode (wr_video_mode),
		.wr_scroll     (wr_scroll),
		.wr_palette    (wr_palette),
		.dout          (dout),
		.video_ctl     (video_ctl),
		.palette_value (palette_value),
		.palette_wren  (palette_wren)
	);

	cpu_data_mux i_cpu_data_mux (
		.status      (status),
		.addr        (addr),
		.rom_disable (rom_disable),
		.rom_data    (rom_data),
		.sram_data   (sram_data),
		.ext_io_data (ext_io_data),
		.din         (din)
	);

	restart_irq i_restart_irq (
		.clk24       (clk24),
		.mreset      (mreset),
		.cpu_ce      (cpu_ce),
		.retrace     (retrace),
		.blksbr      (blksbr),
		.int_req     (int_req),
		.rom_disable (rom_disable),
		.cpu_reset_n (cpu_reset_n)
	);

endmodule

//--- sim/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
	output logic clk24
);
	// 4 ns period
	initial begin
		clk24 = 1'b0;
	end

	always begin
		#2 clk24 = ~clk24;
	end

endmodule

//--- sim/vector_io_assert.sv
`timescale 1ns/1ps

module vector_io_assert (
	input logic clk24,
	input logic mreset,
	input logic cpu_ce,
	input logic int_req,
	input logic rom_disable,
	input logic palette_wren
);
	////////////////////////////////////////////////////////////
	// Pulses
	////////////////////////////////////////////////////////////

	// Palette RAM write enable is a single clock
	a_palette_wren_single: assert property (@(posedge clk24) disable iff (mreset)
		palette_wren |=> !palette_wren)
		else $error("palette_wren high for two clocks in a row");

	a_int_req_one_cycle: assert property (@(posedge clk24) disable iff (mreset)
		(int_req && cpu_ce) |=> !int_req)
		else $error("int_req still high after the next cpu_ce");

	////////////////////////////////////////////////////////////
	// Sticky ROM disable
	////////////////////////////////////////////////////////////

	a_rom_disable_sticky: assert property (@(posedge clk24)
		(rom_disable && !mreset) |=> rom_disable)
		else $error("rom_disable cleared without mreset");

endmodule

bind restart_irq vector_io_assert i_irq_assert (
	.clk24        (clk24),
	.mreset       (mreset),
	.cpu_ce       (cpu_ce),
	.int_req      (int_req),
	.rom_disable  (rom_disable),
	.palette_wren (1'b0)
);

bind video_regs vector_io_assert i_palette_assert (
	.clk24        (clk24),
	.mreset       (mreset),
	.cpu_ce       (1'b0),
	.int_req      (1'b0),
	.rom_disable  (1'b0),
	.palette_wren (palette_wren)
);

//--- sim/tb_vector_io.sv
`timescale 1ns/1ps

module tb_vector_io;
	import vector_pkg::*;

	typedef struct packed {
		page_t page;
		byte_t din;
	} prediction_t;

	localparam int max_cycles = 4000;  // Full run is under 1000 clocks

	logic       clk24;
	logic       mreset;
	logic       cpu_ce = 1'b0;
	logic [1:0] ce_cnt = 2'd0;
	logic       sync;
	logic       wr_n;
	addr_t      addr;
	byte_t      dout;
	byte_t      rom_data;
	byte_t      sram_data;
	byte_t      ext_io_data;
	logic       retrace;
	logic       blksbr;
	byte_t      din;
	logic       ready;
	logic       int_req;
	logic       cpu_reset_n;
	logic       rom_disable;
	page_t      ram_page;
	video_ctl_t video_ctl;
	byte_t      palette_value;
	logic       palette_wren;

	// Model of the DUT registers
	status_t    exp_status;
	byte_t      exp_ramdisk;
	video_ctl_t exp_video;
	logic       exp_rom_disable;
	logic       cmp_on;

	int seed = 24662;
	int errors = 0;
	int errors_seen = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int cycles = 0;

	tb_clock i_tb_clock (.clk24(clk24));

	vector_io i_vector_io (.*);  // Port names match one to one

	// CPU clock enable, one clock in four
	always @(posedge clk24) begin
		ce_cnt <= ce_cnt + 2'd1;
		cpu_ce <= (ce_cnt == 2'd2);
	end

	always @(posedge clk24) begin
		cycles <= cycles + 1;
		if (cycles == max_cycles) begin
			$display("Timeout: tests still running after %0d cycles", max_cycles);
			$display("Result: FAILED");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Reference and compare
	////////////////////////////////////////////////////////////

	function automatic prediction_t predict(byte_t ctl, status_t st, addr_t a,
			logic rom_off, byte_t rom, byte_t sram, byte_t io);
		prediction_t p;
		logic mem_access;
		logic windowed;
		mem_access = st[st_mem_read] || !st[st_write_n];
		windowed = (a >= 16'hA000) && (a <= 16'hDFFF);
		p.page = (ctl[5] && st[st_stack]) ? 3'd1 + page_t'(ctl[3:2]) :
			(ctl[4] && mem_access && windowed) ? 3'd1 + page_t'(ctl[1:0]) : 3'd0;
		if (st[st_interrupt_ack]) begin
			p.din = 8'hFF;
		end else if (st[st_io_read]) begin
			p.din = io;
		end else if (!rom_off && a < 16'd2048) begin
			p.din = rom;  // Boot ROM area
		end else begin
			p.din = sram;
		end
		return p;
	endfunction

	task automatic check(input logic [31:0] got, input logic [31:0] want, input string what);
		if (got !== want) begin
			errors++;
			$display("mismatch at %0t: %s is %0h, expected %0h", $time, what, got, want);
		end
	endtask

	always @(negedge clk24) begin : compare
		prediction_t want;
		if (cmp_on) begin
			want = predict(exp_ramdisk, exp_status, addr, exp_rom_disable,
				rom_data, sram_data, ext_io_data);
			check(32'(ram_page), 32'(want.page), "ram_page");
			check(32'(din), 32'(want.din), "din");
			check(32'(video_ctl), 32'(exp_video), "video_ctl");
			check(32'(rom_disable), 32'(exp_rom_disable), "rom_disable");
		end
	end

	////////////////////////////////////////////////////////////
	// Bus cycles
	////////////////////////////////////////////////////////////

	// Returns on the edge that opens a cpu_ce clock
	task automatic wait_ce_edge();
		do @(posedge clk24); while (ce_cnt != 2'd2);
	endtask

	task automatic sync_cycle(input status_t st, input addr_t a);
		wait_ce_edge();
		sync <= 1'b1;
		dout <= st;
		addr <= a;
		@(posedge clk24);  // Status and port latched here
		sync <= 1'b0;
		exp_status = st;
	endtask

	task automatic io_write(input byte_t p, input byte_t d);
		sync_cycle(8'h10, {p, p});
		wait_ce_edge();
		wr_n <= 1'b0;
		dout <= d;
		@(posedge clk24);
		wr_n <= 1'b1;
		case (p)
			port_ramdisk: exp_ramdisk = d;
			port_scroll: exp_video.scroll = d;
			port_video_mode: begin
				if (retrace) begin
					exp_video.palette_addr = d[3:0];
				end else begin
					exp_video.border_index = d[3:0];
					exp_video.mode512 = d[4];
				end
			end
			default: ;
		endcase
	endtask

	// Random addresses under one latched status, compared every clock
	task automatic random_accesses(input status_t st, input int n);
		int r;
		int d;
		sync_cycle(st, 16'h0000);
		cmp_on = 1'b1;
		repeat (n) begin
			r = $random(seed);
			d = $random(seed);
			case (r[1:0])
				2'd0: addr <= {5'd0, r[12:2]};
				2'd1: addr <= 16'hA000 + {2'd0, r[15:2]};
				default: addr <= r[31:16];
			endcase
			rom_data <= d[7:0];
			sram_data <= d[15:8];
			ext_io_data <= d[23:16];
			@(posedge clk24);
		end
		cmp_on = 1'b0;
	endtask

	task automatic compare_window(input int n);
		@(posedge clk24);
		cmp_on = 1'b1;
		repeat (n) @(posedge clk24);
		cmp_on = 1'b0;
	endtask

	// Counts high clocks and rising edges of int_req or of the restart pulse
	task automatic watch_pulse(input logic restart, input int n, output int high, output int rises);
		logic active;
		logic prev;
		high = 0;
		rises = 0;
		prev = 1'b0;
		repeat (n) begin
			@(negedge clk24);
			active = restart ? !cpu_reset_n : int_req;
			if (active) high++;
			if (active && !prev) rises++;
			prev = active;
		end
	endtask

	task automatic report_test(input string name);
		tests_run++;
		if (errors == errors_seen) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: %0d errors", tests_run, name, errors - errors_seen);
		end
		errors_seen = errors;
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	initial begin
		status_t mix [5];
		int r;
		int high;
		int rises;
		mix = '{8'h86, 8'h04, 8'h82, 8'h00, 8'h42};  // Stack, memory and I/O read
		mreset = 1'b1;
		sync = 1'b0;
		wr_n = 1'b1;
		addr = '0;
		dout = '0;
		rom_data = 8'hC3;
		sram_data = 8'h76;
		ext_io_data = 8'hE5;
		retrace = 1'b0;
		blksbr = 1'b0;
		exp_status = '0;
		exp_ramdisk = '0;
		exp_video = '0;
		exp_rom_disable = 1'b0;
		cmp_on = 1'b0;
		repeat (8) @(posedge clk24);
		mreset <= 1'b0;

		@(negedge clk24);
		check(32'(ready), 32'd1, "ready after reset");
		check(32'(int_req), 32'd0, "int_req after reset");
		check(32'(cpu_reset_n), 32'd1, "cpu_reset_n after reset");
		check(32'(palette_wren), 32'd0, "palette_wren after reset");
		check(32'(rom_disable), 32'd0, "rom_disable after reset");
		sync_cycle(8'hA2, 16'h0100);  // Opcode fetch
		@(negedge clk24);
		check(32'(ready), 32'd0, "ready after memory-read sync");
		wait_ce_edge();
		@(posedge clk24);
		@(negedge clk24);
		check(32'(ready), 32'd1, "ready after the wait state");
		sync_cycle(8'h10, 16'h0101);
		@(negedge clk24);
		check(32'(ready), 32'd1, "ready after I/O-write sync");
		report_test("ready and wait state");

		for (int k = 0; k < 8; k++) begin
			r = $random(seed);
			io_write(port_ramdisk, r[7:0]);
			random_accesses(mix[k % 5], 12);
			random_accesses(mix[(k + 2) % 5], 12);
		end
		report_test("ramdisk mapping");

		io_write(port_scroll, 8'h5B);
		io_write(port_video_mode, 8'h1A);
		retrace <= 1'b1;
		io_write(port_video_mode, 8'h07);  // Lands in palette_addr
		retrace <= 1'b0;
		compare_window(4);
		io_write(port_palette, 8'hE3);
		@(negedge clk24);
		check(32'(palette_wren), 32'd1, "palette_wren after palette write");
		check(32'(palette_value), 32'hE3, "palette_value");
		@(negedge clk24);
		check(32'(palette_wren), 32'd0, "palette_wren one clock later");
		compare_window(4);
		report_test("video registers");

		random_accesses(8'h23, 10);
		random_accesses(8'h42, 10);
		random_accesses(8'hA2, 16);
		random_accesses(8'h82, 16);
		report_test("read data select");

		@(posedge clk24);
		retrace <= 1'b1;
		watch_pulse(1'b0, 24, high, rises);
		check(rises, 32'd1, "int_req pulses on retrace rise");
		check(high, 32'd4, "int_req width in clocks");
		watch_pulse(1'b0, 24, high, rises);
		check(rises, 32'd0, "int_req pulses with retrace held");
		@(posedge clk24);
		retrace <= 1'b0;
		report_test("retrace interrupt");

		@(posedge clk24);
		blksbr <= 1'b1;
		watch_pulse(1'b1, 24, high, rises);
		check(rises, 32'd1, "cpu_reset_n pulses on key press");
		check(high, 32'd4, "cpu_reset_n low clocks");
		@(posedge clk24);
		blksbr <= 1'b0;
		exp_rom_disable = 1'b1;
		random_accesses(8'hA2, 24);
		report_test("restart key");

		$display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

//--- list.f
common/vector_pkg.sv
hdl/bus_control.sv
kvaz/kvaz.sv
hdl/video_regs.sv
hdl/cpu_data_mux.sv
hdl/restart_irq.sv
hdl/vector_io.sv
sim/tb_clock.sv
sim/vector_io_assert.sv
sim/tb_vector_io.sv

//--- run.sh
#!/bin/bash
# Build the testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_vector_io -f list.f -o vector_io_sim \
	&& ./obj_dir/vector_io_sim | tee /dev/stderr | grep "Result: PASSED" > /dev/null \
	&& echo "run.sh: simulation passed" \
	|| { echo "run.sh: simulation did not pass"; exit 1; }
